/* all.f */
+incdir+src
src/obi_pkg.sv
src/soc_ctrl_pkg.sv
src/obi_req_decode.sv
src/pipe_slice.sv
src/periph_regs.sv
src/pad_mux.sv
src/gr_lite_top.sv
bench/tb_gr_lite.sv

/* bench/tb_gr_lite.sv */
// Testbench for gr_lite_top with bus stimulus, register model, response and pad assertions and watchdog
`timescale 1ns/1ps
`include "gr_macros.svh"

module tb_gr_lite;

  localparam int CLK_PERIOD      = 20;
  localparam int NP              = `GR_N_SHARED_PADS;
  localparam int N_RAND          = 64;
  localparam int N_DIRECTED      = 40;
  localparam int N_TXN           = N_RAND + N_DIRECTED;
  localparam int WATCHDOG_CYCLES = N_TXN * 3 + 50;

  localparam logic [31:0] A_GPIO_OUT = `GR_PERIPH_BASE + `GR_OFF_GPIO_OUT;
  localparam logic [31:0] A_GPIO_OE  = `GR_PERIPH_BASE + `GR_OFF_GPIO_OE;
  localparam logic [31:0] A_GPIO_IN  = `GR_PERIPH_BASE + `GR_OFF_GPIO_IN;
  localparam logic [31:0] A_PAD_MUX  = `GR_PERIPH_BASE + `GR_OFF_PAD_MUX;
  localparam logic [31:0] A_EXIT     = `GR_PERIPH_BASE + `GR_OFF_EXIT;
  localparam logic [31:0] A_SCRATCH  = `GR_PERIPH_BASE + `GR_OFF_SCRATCH;

  logic          clk;
  logic          rst_n;
  logic          req;
  logic          we;
  logic [3:0]    be;
  logic [31:0]   addr;
  logic [31:0]   wdata;
  logic          gnt;
  logic          rvalid;
  logic [31:0]   rdata;
  logic [NP-1:0] pad_in;
  logic [NP-1:0] pad_out;
  logic [NP-1:0] pad_oe;
  logic          exit_valid;
  logic [31:0]   exit_value;

  // Register model and expected responses in grant order
  logic [NP-1:0] m_gpio_out;
  logic [NP-1:0] m_gpio_oe;
  logic [NP-1:0] m_pad_mux;
  logic [31:0]   m_exit;
  logic          m_exit_valid;
  logic [31:0]   m_scratch;
  logic [31:0]   exp_q[$];
  logic [31:0]   exp_rdata;
  logic [NP-1:0] exp_pad_out;
  logic [NP-1:0] exp_pad_oe;
  logic [31:0]   rng_state;

  gr_lite_top dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .we_i        (we),
    .be_i        (be),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .gnt_o       (gnt),
    .rvalid_o    (rvalid),
    .rdata_o     (rdata),
    .pad_i       (pad_in),
    .pad_o       (pad_out),
    .pad_oe_o    (pad_oe),
    .exit_valid_o(exit_valid),
    .exit_value_o(exit_value)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_fail(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic rand_word(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] apply_be(input logic [31:0] old_w, input logic [31:0] new_w,
                                           input logic [3:0] b);
    logic [31:0] w;
    w = old_w;
    for (int i = 0; i < 4; i++) begin
      if (b[i]) w[8*i +: 8] = new_w[8*i +: 8];
    end
    return w;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] a);
    logic [31:0] rel;
    rel = a - `GR_PERIPH_BASE;
    if (rel >= `GR_PERIPH_SIZE) return `GR_ERR_RDATA;
    case (rel[5:0])
      `GR_OFF_GPIO_OUT: return 32'(m_gpio_out);
      `GR_OFF_GPIO_OE:  return 32'(m_gpio_oe);
      // Pads in exit mode read back as zero
      `GR_OFF_GPIO_IN:  return 32'(pad_in & ~m_pad_mux);
      `GR_OFF_PAD_MUX:  return 32'(m_pad_mux);
      `GR_OFF_EXIT:     return m_exit;
      `GR_OFF_SCRATCH:  return m_scratch;
      default:          return `GR_ERR_RDATA;
    endcase
  endfunction

  task automatic model_write(input logic [31:0] a, input logic [3:0] b, input logic [31:0] d);
    logic [31:0] rel;
    rel = a - `GR_PERIPH_BASE;
    if (rel < `GR_PERIPH_SIZE) begin
      case (rel[5:0])
        `GR_OFF_GPIO_OUT: if (b[0]) m_gpio_out = d[NP-1:0];
        `GR_OFF_GPIO_OE:  if (b[0]) m_gpio_oe = d[NP-1:0];
        `GR_OFF_PAD_MUX:  if (b[0]) m_pad_mux = d[NP-1:0];
        `GR_OFF_EXIT: begin
          m_exit       = apply_be(m_exit, d, b);
          m_exit_valid = 1'b1;
        end
        `GR_OFF_SCRATCH:  m_scratch = apply_be(m_scratch, d, b);
        default: ;
      endcase
    end
  endtask

  // Response check before the new grant within one process
  always @(posedge clk) begin
    if (!rst_n) begin
      m_gpio_out   = '0;
      m_gpio_oe    = '0;
      m_pad_mux    = '0;
      m_exit       = '0;
      m_exit_valid = 1'b0;
      m_scratch    = '0;
      exp_q.delete();
    end else begin
      if (rvalid) begin
        if (exp_q.size() == 0) begin
          report_fail("response with no request outstanding");
        end else begin
          exp_rdata = exp_q.pop_front();
          assert (rdata === exp_rdata)
            else report_fail($sformatf("rdata %h, expected %h", rdata, exp_rdata));
        end
      end
      if (req && gnt) begin
        if (we) begin
          model_write(addr, be, wdata);
          exp_q.push_back('0);
        end else begin
          exp_q.push_back(model_read(addr));
        end
      end
    end
  end

  // Pad 0 carries exit valid and pad 1 exit value bit 0
  always_comb begin
    for (int k = 0; k < NP; k++) begin
      if (m_pad_mux[k]) begin
        exp_pad_out[k] = (k == 0) ? m_exit_valid : m_exit[0];
        exp_pad_oe[k]  = 1'b1;
      end else begin
        exp_pad_out[k] = m_gpio_out[k];
        exp_pad_oe[k]  = m_gpio_oe[k];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------
  gnt_follows_req: assert property (@(posedge clk) gnt == req)
    else report_fail("gnt_o differs from req_i");

  rvalid_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid == $past(req && gnt, 2))
    else report_fail("rvalid_o not exactly 2 cycles after a grant");

  reset_outputs_low: assert property (@(posedge clk)
    !rst_n |=> (!rvalid && !exit_valid && pad_oe == '0))
    else report_fail("rvalid_o, exit_valid_o or pad_oe_o high after reset");

  // Compared only when no write can be in flight
  pads_match_model: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(req) |-> (pad_out == exp_pad_out && pad_oe == exp_pad_oe))
    else report_fail($sformatf("pads %b/%b, expected %b/%b",
                               pad_out, pad_oe, exp_pad_out, exp_pad_oe));

  exit_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(req) |-> (exit_valid == m_exit_valid && exit_value == m_exit))
    else report_fail($sformatf("exit %b/%h, expected %b/%h",
                               exit_valid, exit_value, m_exit_valid, m_exit));

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  task automatic issue(input logic wr, input logic [3:0] b, input logic [31:0] a,
                       input logic [31:0] d);
    req   = 1'b1;
    we    = wr;
    be    = b;
    addr  = a;
    wdata = d;
    @(posedge clk);
    #1;
  endtask

  // Idle the bus until every response is back and one more quiet cycle
  task automatic drain();
    req = 1'b0;
    we  = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] good_addr(input int i);
    case (i)
      0:       return A_GPIO_OUT;
      1:       return A_GPIO_OE;
      2:       return A_GPIO_IN;
      3:       return A_PAD_MUX;
      4:       return A_EXIT;
      default: return A_SCRATCH;
    endcase
  endfunction

  // Below, above and beside the window and unmapped offsets inside it
  function automatic logic [31:0] bad_addr(input int i);
    case (i)
      0:       return `GR_PERIPH_BASE - 32'h4;
      1:       return `GR_PERIPH_BASE + `GR_PERIPH_SIZE;
      2:       return `GR_PERIPH_BASE + `GR_PERIPH_SIZE + `GR_OFF_SCRATCH;
      3:       return 32'h0000_0010;
      4:       return `GR_PERIPH_BASE + 32'h18;
      default: return `GR_PERIPH_BASE + 32'h3C;
    endcase
  endfunction

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    be        = '0;
    addr      = '0;
    wdata     = '0;
    pad_in    = '0;
    rng_state = 32'h144f;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Registers read back as zero after reset
    for (int i = 0; i < 6; i++) issue(1'b0, 4'hF, good_addr(i), '0);
    drain();

    // Byte-enable writes with an immediate read-back
    issue(1'b1, 4'b0101, A_SCRATCH, 32'h1122_3344);
    issue(1'b0, 4'hF, A_SCRATCH, '0);
    issue(1'b1, 4'b1010, A_SCRATCH, 32'hAABB_CCDD);
    issue(1'b0, 4'hF, A_SCRATCH, '0);
    drain();

    // Back-to-back random traffic with the odd idle cycle
    for (int i = 0; i < N_RAND; i++) begin
      rand_word(r);
      rand_word(d);
      case (r[1:0])
        2'd0, 2'd1: issue(1'b1, r[7:4], A_SCRATCH, d);
        2'd2:       issue(1'b0, 4'hF, A_SCRATCH, d);
        default:    issue(r[8], r[7:4], r[9] ? A_GPIO_OE : A_GPIO_OUT, d);
      endcase
      if (r[12:10] == 3'd0) begin
        req = 1'b0;
        @(posedge clk);
        #1;
      end
    end
    drain();

    // Pads in GPIO mode
    issue(1'b1, 4'hF, A_GPIO_OUT, 32'h2);
    issue(1'b1, 4'hF, A_GPIO_OE, 32'h3);
    issue(1'b0, 4'hF, A_GPIO_OUT, '0);
    issue(1'b0, 4'hF, A_GPIO_OE, '0);
    drain();
    pad_in = 2'b01;
    issue(1'b0, 4'hF, A_GPIO_IN, '0);
    drain();
    pad_in = 2'b10;
    issue(1'b0, 4'hF, A_GPIO_IN, '0);
    drain();

    // Exit status and then both pads switched to exit mode
    issue(1'b1, 4'hF, A_EXIT, 32'hA5A5_0001);
    issue(1'b0, 4'hF, A_EXIT, '0);
    drain();
    issue(1'b1, 4'hF, A_PAD_MUX, 32'h3);
    issue(1'b0, 4'hF, A_PAD_MUX, '0);
    issue(1'b0, 4'hF, A_GPIO_IN, '0);
    drain();
    issue(1'b1, 4'b0001, A_EXIT, 32'h0000_0002);
    drain();

    // Decode errors leave all registers untouched
    for (int i = 0; i < 6; i++) issue(1'b0, 4'hF, bad_addr(i), '0);
    for (int i = 0; i < 6; i++) issue(1'b1, 4'hF, bad_addr(i), 32'hFFFF_FFFF);
    for (int i = 0; i < 6; i++) issue(1'b0, 4'hF, good_addr(i), '0);
    drain();

    repeat (2) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* src/gr_lite_top.sv */
// Top level: request decode, request and response slices, registers, pad mux
`timescale 1ns/1ps
`include "gr_macros.svh"

module gr_lite_top import obi_pkg::*, soc_ctrl_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  // OBI request
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [`GR_BE_W-1:0]          be_i,
  input  logic [`GR_ADDR_W-1:0]        addr_i,
  input  logic [`GR_DATA_W-1:0]        wdata_i,

  // OBI response
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output logic [`GR_DATA_W-1:0]        rdata_o,

  // Shared pads
  input  logic [`GR_N_SHARED_PADS-1:0] pad_i,
  output logic [`GR_N_SHARED_PADS-1:0] pad_o,
  output logic [`GR_N_SHARED_PADS-1:0] pad_oe_o,

  // Exit status
  output logic                         exit_valid_o,
  output logic [`GR_DATA_W-1:0]        exit_value_o
);

  // Request path
  logic                         req_valid;
  reg_req_t                     req_d;
  logic                         req_valid_q;
  reg_req_t                     req_q;

  // Response path
  reg_rsp_t                     rsp_d;
  reg_rsp_t                     rsp_q;

  // Pad controls
  logic [`GR_N_SHARED_PADS-1:0] gpio_out;
  logic [`GR_N_SHARED_PADS-1:0] gpio_oe;
  logic [`GR_N_SHARED_PADS-1:0] gpio_in;
  pad_sel_t                     pad_sel;

  // ----------------------------------------------------------------------
  // Bus front end and pipeline
  // ----------------------------------------------------------------------
  obi_req_decode u_req_decode (
    .req_i      (req_i),
    .we_i       (we_i),
    .be_i       (be_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .gnt_o      (gnt_o),
    .req_valid_o(req_valid),
    .req_o      (req_d)
  );

  pipe_slice #(.payload_t(reg_req_t)) u_req_slice (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(req_valid),
    .data_i (req_d),
    .valid_o(req_valid_q),
    .data_o (req_q)
  );

  pipe_slice #(.payload_t(reg_rsp_t)) u_rsp_slice (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(req_valid_q),
    .data_i (rsp_d),
    .valid_o(rvalid_o),
    .data_o (rsp_q)
  );

  assign rdata_o = rsp_q.rdata;

  // ----------------------------------------------------------------------
  // Registers and pads
  // ----------------------------------------------------------------------
  periph_regs u_periph_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (req_valid_q),
    .req_i       (req_q),
    .gpio_in_i   (gpio_in),
    .rsp_o       (rsp_d),
    .gpio_out_o  (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .pad_sel_o   (pad_sel),
    .exit_valid_o(exit_valid_o),
    .exit_value_o(exit_value_o)
  );

  // Only bit 0 of the exit value reaches a pad
  pad_mux u_pad_mux (
    .gpio_out_i  (gpio_out),
    .gpio_oe_i   (gpio_oe),
    .gpio_in_o   (gpio_in),
    .pad_sel_i   (pad_sel),
    .exit_valid_i(exit_valid_o),
    .exit_bit_i  (exit_value_o[0]),
    .pad_i       (pad_i),
    .pad_o       (pad_o),
    .pad_oe_o    (pad_oe_o)
  );

endmodule

/* src/gr_macros.svh */
// Bus widths, peripheral window, register offsets, error pattern and shared-pad count
`ifndef GR_MACROS_SVH
`define GR_MACROS_SVH

// Bus widths
`define GR_DATA_W 32
`define GR_ADDR_W 32
`define GR_BE_W   4

// Peripheral window
`define GR_PERIPH_BASE 32'h2000_0000
`define GR_PERIPH_SIZE 32'h40
`define GR_OFF_W       6

// Register byte offsets inside the window
`define GR_OFF_GPIO_OUT 6'h00
`define GR_OFF_GPIO_OE  6'h04
`define GR_OFF_GPIO_IN  6'h08
`define GR_OFF_PAD_MUX  6'h0C
`define GR_OFF_EXIT     6'h10
`define GR_OFF_SCRATCH  6'h14

`define GR_ERR_RDATA     32'hBADC_AB1E
`define GR_N_SHARED_PADS 2

`endif

/* src/obi_pkg.sv */
// Request and response payload types of the peripheral side of the bus
`include "gr_macros.svh"

package obi_pkg;

  // ----------------------------------------------------------------------
  // Request payload, one granted bus transfer
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                  we;
    logic [`GR_BE_W-1:0]   be;
    logic [`GR_OFF_W-1:0]  offset;
    logic [`GR_DATA_W-1:0] wdata;
    // Set when the address hit the peripheral window
    logic                  in_window;
  } reg_req_t;

  // ----------------------------------------------------------------------
  // Response payload
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`GR_DATA_W-1:0] rdata;
  } reg_rsp_t;

endpackage

/* src/obi_req_decode.sv */
// Request front end with immediate grant and peripheral window check
`timescale 1ns/1ps
`include "gr_macros.svh"

module obi_req_decode import obi_pkg::*; (
  // Bus request
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [`GR_BE_W-1:0]   be_i,
  input  logic [`GR_ADDR_W-1:0] addr_i,
  input  logic [`GR_DATA_W-1:0] wdata_i,

  // Grant back to the bus
  output logic                  gnt_o,

  // Towards the request slice
  output logic                  req_valid_o,
  output reg_req_t              req_o
);

  logic [`GR_ADDR_W-1:0] addr_rel;
  logic                  in_window;

  // ----------------------------------------------------------------------
  // Grant
  // ----------------------------------------------------------------------
  // Every request is accepted in its own cycle
  assign gnt_o       = req_i;
  assign req_valid_o = req_i & gnt_o;

  // ----------------------------------------------------------------------
  // Window check
  // ----------------------------------------------------------------------
  // Addresses below the base wrap to large values and fail the compare
  assign addr_rel  = addr_i - `GR_PERIPH_BASE;
  assign in_window = (addr_rel < `GR_PERIPH_SIZE);

  always_comb begin
    req_o.we        = we_i;
    req_o.be        = be_i;
    req_o.offset    = addr_rel[`GR_OFF_W-1:0];
    req_o.wdata     = wdata_i;
    req_o.in_window = in_window;
  end

endmodule

/* src/pad_mux.sv */
// Shared-pad routing between GPIO and exit functions
`timescale 1ns/1ps
`include "gr_macros.svh"

module pad_mux import soc_ctrl_pkg::*; (
  // GPIO side
  input  logic [`GR_N_SHARED_PADS-1:0] gpio_out_i,
  input  logic [`GR_N_SHARED_PADS-1:0] gpio_oe_i,
  output logic [`GR_N_SHARED_PADS-1:0] gpio_in_o,

  // Function select and exit status
  input  pad_sel_t                     pad_sel_i,
  input  logic                         exit_valid_i,
  input  logic                         exit_bit_i,

  // Pad side
  input  logic [`GR_N_SHARED_PADS-1:0] pad_i,
  output logic [`GR_N_SHARED_PADS-1:0] pad_o,
  output logic [`GR_N_SHARED_PADS-1:0] pad_oe_o
);

  logic [`GR_N_SHARED_PADS-1:0] exit_func;

  // Pad 0 carries exit_valid and pad 1 the low exit-value bit
  assign exit_func[0] = exit_valid_i;
  assign exit_func[1] = exit_bit_i;

  always_comb begin
    for (int k = 0; k < `GR_N_SHARED_PADS; k++) begin
      if (pad_sel_i[k] == PAD_EXIT) begin
        pad_o[k]     = exit_func[k];
        pad_oe_o[k]  = 1'b1;
        gpio_in_o[k] = 1'b0;
      end else begin
        pad_o[k]     = gpio_out_i[k];
        pad_oe_o[k]  = gpio_oe_i[k];
        gpio_in_o[k] = pad_i[k];
      end
    end
  end

endmodule

/* src/periph_regs.sv */
// Control registers: GPIO, pad mux, exit and scratch, byte-enable writes, read mux
`timescale 1ns/1ps
`include "gr_macros.svh"

module periph_regs import obi_pkg::*, soc_ctrl_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  // Request from the request slice
  input  logic                         valid_i,
  input  reg_req_t                     req_i,
  input  logic [`GR_N_SHARED_PADS-1:0] gpio_in_i,

  // Response towards the response slice
  output reg_rsp_t                     rsp_o,

  // Pad and exit controls
  output logic [`GR_N_SHARED_PADS-1:0] gpio_out_o,
  output logic [`GR_N_SHARED_PADS-1:0] gpio_oe_o,
  output pad_sel_t                     pad_sel_o,
  output logic                         exit_valid_o,
  output logic [`GR_DATA_W-1:0]        exit_value_o
);

  localparam int unsigned NPads = `GR_N_SHARED_PADS;

  logic [NPads-1:0]      gpio_out_q;
  logic [NPads-1:0]      gpio_oe_q;
  logic [NPads-1:0]      pad_mux_q;
  logic [`GR_DATA_W-1:0] exit_q;
  logic [`GR_DATA_W-1:0] scratch_q;
  logic                  exit_valid_q;

  reg_idx_e              reg_idx;
  logic                  reg_hit;
  logic                  hit;
  logic                  wr_en;
  logic [`GR_DATA_W-1:0] rdata;

  // Merge write data into an old word under the byte enables
  function automatic logic [`GR_DATA_W-1:0] be_merge(
    input logic [`GR_DATA_W-1:0] old_val,
    input logic [`GR_DATA_W-1:0] new_val,
    input logic [`GR_BE_W-1:0]   be
  );
    logic [`GR_DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < `GR_BE_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // Offset decode
  // ----------------------------------------------------------------------
  always_comb begin
    reg_hit = 1'b1;
    reg_idx = REG_GPIO_OUT;
    case (req_i.offset)
      `GR_OFF_GPIO_OUT: reg_idx = REG_GPIO_OUT;
      `GR_OFF_GPIO_OE:  reg_idx = REG_GPIO_OE;
      `GR_OFF_GPIO_IN:  reg_idx = REG_GPIO_IN;
      `GR_OFF_PAD_MUX:  reg_idx = REG_PAD_MUX;
      `GR_OFF_EXIT:     reg_idx = REG_EXIT;
      `GR_OFF_SCRATCH:  reg_idx = REG_SCRATCH;
      default:          reg_hit = 1'b0;
    endcase
  end

  assign hit   = req_i.in_window & reg_hit;
  assign wr_en = valid_i & req_i.we & hit;

  // ----------------------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------------------
  // Narrow registers only see byte 0
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_out_q   <= '0;
      gpio_oe_q    <= '0;
      pad_mux_q    <= '0;
      exit_q       <= '0;
      scratch_q    <= '0;
      exit_valid_q <= 1'b0;
    end else if (wr_en) begin
      case (reg_idx)
        REG_GPIO_OUT: if (req_i.be[0]) gpio_out_q <= req_i.wdata[NPads-1:0];
        REG_GPIO_OE:  if (req_i.be[0]) gpio_oe_q <= req_i.wdata[NPads-1:0];
        REG_PAD_MUX:  if (req_i.be[0]) pad_mux_q <= req_i.wdata[NPads-1:0];
        REG_EXIT: begin
          exit_q       <= be_merge(exit_q, req_i.wdata, req_i.be);
          exit_valid_q <= 1'b1;
        end
        REG_SCRATCH:  scratch_q <= be_merge(scratch_q, req_i.wdata, req_i.be);
        default:      ;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  // Writes answer with zero, decode errors with the error pattern
  always_comb begin
    rdata = '0;
    if (valid_i && !req_i.we) begin
      if (!hit) begin
        rdata = `GR_ERR_RDATA;
      end else begin
        case (reg_idx)
          REG_GPIO_OUT: rdata[NPads-1:0] = gpio_out_q;
          REG_GPIO_OE:  rdata[NPads-1:0] = gpio_oe_q;
          REG_GPIO_IN:  rdata[NPads-1:0] = gpio_in_i;
          REG_PAD_MUX:  rdata[NPads-1:0] = pad_mux_q;
          REG_EXIT:     rdata = exit_q;
          REG_SCRATCH:  rdata = scratch_q;
          default:      rdata = `GR_ERR_RDATA;
        endcase
      end
    end
  end

  assign rsp_o.rdata  = rdata;
  assign gpio_out_o   = gpio_out_q;
  assign gpio_oe_o    = gpio_oe_q;
  assign pad_sel_o    = pad_sel_t'(pad_mux_q);
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_q;

  // Exit is sticky, only a reset may clear it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) && $past(exit_valid_o) |-> exit_valid_o)
    else $error("exit_valid_o dropped outside reset");

endmodule

/* src/pipe_slice.sv */
// One-stage pipeline register for a valid strobe and a typed payload
`timescale 1ns/1ps

module pipe_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Upstream side
  input  logic     valid_i,
  input  payload_t data_i,

  // Downstream side, one cycle later
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Control strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Payload follows every cycle
  always_ff @(posedge clk_i) begin
    data_q <= data_i;
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Output strobe only ever comes from an input strobe one cycle back
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> $past(valid_i))
    else $error("valid_o without valid_i one cycle earlier");

endmodule

/* src/soc_ctrl_pkg.sv */
// Register index enum and shared-pad function types
`include "gr_macros.svh"

package soc_ctrl_pkg;

  // Registers of the control block
  typedef enum logic [2:0] {
    REG_GPIO_OUT = 3'd0,
    REG_GPIO_OE  = 3'd1,
    REG_GPIO_IN  = 3'd2,
    REG_PAD_MUX  = 3'd3,
    REG_EXIT     = 3'd4,
    REG_SCRATCH  = 3'd5
  } reg_idx_e;

  // Function carried by one shared pad
  typedef enum logic {
    PAD_GPIO = 1'b0,
    PAD_EXIT = 1'b1
  } pad_func_e;

  // One entry per shared pad
  typedef pad_func_e [`GR_N_SHARED_PADS-1:0] pad_sel_t;

endpackage
